// ==== spi_sine_pkg.sv ====
package spi_sine_pkg;

    // SPI timing
    localparam int CLKS_PER_HALF_BIT = 2;            // System clocks per SPI half period
    localparam int WORD_BYTES        = 2;            // Bytes per CS-low transaction

    // Command byte sent in every byte slot
    localparam logic [7:0] REQ_COMMAND = 8'h21;

    // Request word fields, first byte high
    localparam int INDEX_W = 12;                     // Sine index, upper bits of word
    localparam int ID_W    = 4;                      // UART id, lower bits of word

    // Sine lookup
    localparam int    SAMPLE_W   = 12;               // Signed sample width
    localparam int    LUT_ADDR_W = 5;                // 32 entries per quarter wave
    localparam string LUT_FILE   = "sine_quarter.hex";

    // Output channels
    localparam int NUM_UART = 4;                     // Ids at or above this are errors

endpackage

// ==== spi_master_cs.sv ====
module spi_master_cs
    import spi_sine_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       i_tx_dv,                      // Byte load strobe
    input  logic [7:0] i_tx_byte,
    output logic       o_ready,                      // Can take a byte this cycle
    output logic       o_rx_dv,                      // One-cycle pulse per received byte
    output logic [7:0] o_rx_byte,
    output logic       o_spi_clk,
    output logic       o_spi_mosi,
    output logic       o_spi_cs_n,
    input  logic       i_spi_miso
);

    typedef enum logic [1:0] {
        ST_IDLE,                                     // CS high while waiting for first byte
        ST_SHIFT,                                    // Clocking a byte
        ST_WAIT                                      // CS held low between bytes
    } state_t;

    state_t state;

    logic [$clog2(CLKS_PER_HALF_BIT + 1)-1:0] r_half_cnt;   // Clocks within half period
    logic [3:0]                               r_edge_cnt;   // 16 SPI edges per byte
    logic [$clog2(WORD_BYTES + 1)-1:0]        r_byte_cnt;   // Bytes done in this CS window
    logic [7:0]                               r_tx_shift;
    logic [7:0]                               r_rx_shift;
    logic                                     w_half_tick;
    logic                                     w_last_byte;

    assign w_half_tick = (r_half_cnt == CLKS_PER_HALF_BIT - 1);
    assign w_last_byte = (r_byte_cnt == WORD_BYTES - 1);

    assign o_ready    = (state == ST_IDLE) || (state == ST_WAIT);
    assign o_spi_mosi = r_tx_shift[7];               // MSB first and valid before rising edge

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            r_half_cnt <= '0;
            r_edge_cnt <= '0;
            r_byte_cnt <= '0;
            r_tx_shift <= '0;                        // Keeps MOSI low at idle
            o_rx_dv    <= 1'b0;
            o_spi_clk  <= 1'b0;                      // Mode 0 idles low
            o_spi_cs_n <= 1'b1;
        end else begin
            o_rx_dv <= 1'b0;                         // Pulse by default
            case (state)
                ST_IDLE, ST_WAIT: begin
                    if (i_tx_dv) begin
                        r_tx_shift <= i_tx_byte;     // First bit out right away
                        r_half_cnt <= '0;
                        r_edge_cnt <= '0;
                        o_spi_cs_n <= 1'b0;          // Half period of CS setup before edge
                        state      <= ST_SHIFT;
                    end
                end

                ST_SHIFT: begin
                    if (w_half_tick) begin
                        r_half_cnt <= '0;
                        r_edge_cnt <= r_edge_cnt + 1'b1;
                        o_spi_clk  <= ~o_spi_clk;
                        if (!o_spi_clk) begin        // Rising edge samples MISO
                            r_rx_shift <= {r_rx_shift[6:0], i_spi_miso};
                        end else begin               // Falling edge moves to next MOSI bit
                            r_tx_shift <= {r_tx_shift[6:0], 1'b0};
                        end
                        if (r_edge_cnt == 4'hF) begin    // Final falling edge of the byte
                            o_rx_dv   <= 1'b1;
                            o_rx_byte <= r_rx_shift;
                            if (w_last_byte) begin
                                r_byte_cnt <= '0;
                                o_spi_cs_n <= 1'b1;  // Release after last bit
                                state      <= ST_IDLE;
                            end else begin
                                r_byte_cnt <= r_byte_cnt + 1'b1;
                                state      <= ST_WAIT;
                            end
                        end
                    end else begin
                        r_half_cnt <= r_half_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Requester only loads a byte when the master can take it
    a_tx_dv_when_ready: assert property (
        @(posedge clk) disable iff (reset)
        i_tx_dv |-> o_ready
    );

endmodule

// ==== spi_word_request.sv ====
module spi_word_request
    import spi_sine_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               i_start,              // Opens one two-byte request
    output logic               o_busy,
    output logic               o_tx_dv,
    output logic [7:0]         o_tx_byte,
    input  logic               i_ready,
    input  logic               i_rx_dv,
    input  logic [7:0]         i_rx_byte,
    output logic               o_word_valid,         // One-cycle pulse per word
    output logic [INDEX_W-1:0] o_sin_index,
    output logic [ID_W-1:0]    o_uart_id
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_HI,                                  // First byte, word MSBs
        ST_WAIT_LO,                                  // Second byte, word LSBs
        ST_DELIVER
    } state_t;

    state_t state;

    logic [INDEX_W+ID_W-1:0] r_word;                 // Assembled request word

    assign o_busy       = (state != ST_IDLE);
    assign o_tx_byte    = REQ_COMMAND;               // Same command in every slot
    assign o_word_valid = (state == ST_DELIVER);
    assign o_sin_index  = r_word[INDEX_W+ID_W-1:ID_W];
    assign o_uart_id    = r_word[ID_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            o_tx_dv <= 1'b0;
        end else begin
            o_tx_dv <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_start && i_ready) begin    // Start while busy is dropped
                        o_tx_dv <= 1'b1;             // First byte next cycle
                        state   <= ST_WAIT_HI;
                    end
                end

                ST_WAIT_HI: begin
                    if (i_rx_dv) begin
                        r_word[INDEX_W+ID_W-1 -: 8] <= i_rx_byte;
                        o_tx_dv <= 1'b1;             // Second byte, CS still low
                        state   <= ST_WAIT_LO;
                    end
                end

                ST_WAIT_LO: begin
                    if (i_rx_dv) begin
                        r_word[7:0] <= i_rx_byte;
                        state       <= ST_DELIVER;
                    end
                end

                ST_DELIVER: begin
                    state <= ST_IDLE;                // Word valid for this cycle only
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Master only reports bytes this FSM asked for
    a_no_rx_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        (state == ST_IDLE) |-> !i_rx_dv
    );

endmodule

// ==== sine_quarter_lut.sv ====
module sine_quarter_lut
    import spi_sine_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_valid,
    input  logic [INDEX_W-1:0]         i_index,
    input  logic [ID_W-1:0]            i_uart_id,
    output logic                       o_sample_valid,
    output logic signed [SAMPLE_W-1:0] o_sample,
    output logic [ID_W-1:0]            o_uart_id     // Follows the sample
);

    logic [SAMPLE_W-1:0] rom [2**LUT_ADDR_W];        // First quarter magnitudes

    logic [1:0]                w_quadrant;
    logic [LUT_ADDR_W-1:0]     w_addr_raw;
    logic [LUT_ADDR_W-1:0]     w_addr;
    logic signed [SAMPLE_W-1:0] w_mag;

    initial begin
        $readmemh(LUT_FILE, rom);
    end

    assign w_quadrant = i_index[INDEX_W-1 -: 2];
    assign w_addr_raw = i_index[INDEX_W-3 -: LUT_ADDR_W];
    assign w_addr     = w_quadrant[0] ? ~w_addr_raw : w_addr_raw;   // 31 - addr in Q1, Q3
    assign w_mag      = rom[w_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            o_sample_valid <= 1'b0;
        end else begin
            o_sample_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_sample  <= w_quadrant[1] ? -w_mag : w_mag;   // Lower half wave in Q2, Q3
            o_uart_id <= i_uart_id;
        end
    end

endmodule

// ==== sample_dispatch.sv ====
module sample_dispatch
    import spi_sine_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_valid,
    input  logic signed [SAMPLE_W-1:0] i_sample,
    input  logic [ID_W-1:0]            i_uart_id,
    output logic [NUM_UART-1:0]        o_chan_valid, // One strobe per channel
    output logic signed [SAMPLE_W-1:0] o_chan_sample,// Last routed sample
    output logic                       o_id_error    // Id with no channel
);

    logic w_id_ok;

    assign w_id_ok = (i_uart_id < ID_W'(NUM_UART));

    always_ff @(posedge clk) begin
        if (reset) begin
            o_chan_valid <= '0;
            o_id_error   <= 1'b0;
        end else begin
            o_chan_valid <= '0;
            o_id_error   <= 1'b0;
            if (i_valid) begin
                if (w_id_ok) begin
                    o_chan_valid <= NUM_UART'(1) << i_uart_id;   // One-hot by id
                end else begin
                    o_id_error <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && w_id_ok) begin
            o_chan_sample <= i_sample;               // Bad ids leave it unchanged
        end
    end

    // At most one channel per sample, never together with an error
    a_one_result: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({o_chan_valid, o_id_error})
    );

endmodule

// ==== spi_sine_top.sv ====
module spi_sine_top
    import spi_sine_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_start,
    input  logic                       i_spi_miso,
    output logic                       o_spi_clk,
    output logic                       o_spi_mosi,
    output logic                       o_spi_cs_n,
    output logic                       o_busy,
    output logic [NUM_UART-1:0]        o_chan_valid,
    output logic signed [SAMPLE_W-1:0] o_chan_sample,
    output logic                       o_id_error
);

    // Requester to master
    logic       w_tx_dv;
    logic [7:0] w_tx_byte;
    logic       w_ready;
    logic       w_rx_dv;
    logic [7:0] w_rx_byte;

    // Requester to lookup
    logic               w_word_valid;
    logic [INDEX_W-1:0] w_sin_index;
    logic [ID_W-1:0]    w_word_id;

    // Lookup to dispatcher
    logic                       w_sample_valid;
    logic signed [SAMPLE_W-1:0] w_sample;
    logic [ID_W-1:0]            w_sample_id;

    spi_master_cs u_master (
        .clk        (clk),
        .reset      (reset),
        .i_tx_dv    (w_tx_dv),
        .i_tx_byte  (w_tx_byte),
        .o_ready    (w_ready),
        .o_rx_dv    (w_rx_dv),
        .o_rx_byte  (w_rx_byte),
        .o_spi_clk  (o_spi_clk),
        .o_spi_mosi (o_spi_mosi),
        .o_spi_cs_n (o_spi_cs_n),
        .i_spi_miso (i_spi_miso)
    );

    spi_word_request u_request (
        .clk          (clk),
        .reset        (reset),
        .i_start      (i_start),
        .o_busy       (o_busy),
        .o_tx_dv      (w_tx_dv),
        .o_tx_byte    (w_tx_byte),
        .i_ready      (w_ready),
        .i_rx_dv      (w_rx_dv),
        .i_rx_byte    (w_rx_byte),
        .o_word_valid (w_word_valid),
        .o_sin_index  (w_sin_index),
        .o_uart_id    (w_word_id)
    );

    sine_quarter_lut u_lut (
        .clk            (clk),
        .reset          (reset),
        .i_valid        (w_word_valid),
        .i_index        (w_sin_index),
        .i_uart_id      (w_word_id),
        .o_sample_valid (w_sample_valid),
        .o_sample       (w_sample),
        .o_uart_id      (w_sample_id)
    );

    sample_dispatch u_dispatch (
        .clk           (clk),
        .reset         (reset),
        .i_valid       (w_sample_valid),
        .i_sample      (w_sample),
        .i_uart_id     (w_sample_id),
        .o_chan_valid  (o_chan_valid),
        .o_chan_sample (o_chan_sample),
        .o_id_error    (o_id_error)
    );

endmodule

// ==== spi_slave_model.sv ====
module spi_slave_model
    import spi_sine_pkg::*;
(
    input  logic [INDEX_W+ID_W-1:0] i_word,          // Word returned on MISO
    input  logic                    i_spi_clk,
    input  logic                    i_spi_mosi,
    input  logic                    i_spi_cs_n,
    output logic                    o_spi_miso,
    output logic [INDEX_W+ID_W-1:0] o_rx_word,       // Last bits seen on MOSI
    output logic [7:0]              o_bit_count      // Bits in current CS window
);

    logic [INDEX_W+ID_W-1:0] r_tx_shift = '0;
    logic [INDEX_W+ID_W-1:0] r_rx_shift = '0;
    logic [7:0]              r_bit_count = '0;

    assign o_spi_miso  = (i_spi_cs_n === 1'b0) ? r_tx_shift[INDEX_W+ID_W-1] : 1'b0;
    assign o_rx_word   = r_rx_shift;
    assign o_bit_count = r_bit_count;

    // New window, first bit goes out with CS
    always @(negedge i_spi_cs_n) begin
        r_tx_shift  <= i_word;
        r_bit_count <= '0;
    end

    always @(posedge i_spi_clk) begin
        if (!i_spi_cs_n) begin                       // Mode 0 capture on rising edge
            r_rx_shift  <= {r_rx_shift[INDEX_W+ID_W-2:0], i_spi_mosi};
            r_bit_count <= r_bit_count + 1'b1;
        end
    end

    always @(negedge i_spi_clk) begin
        r_tx_shift <= {r_tx_shift[INDEX_W+ID_W-2:0], 1'b0};   // Next bit after falling edge
    end

endmodule

// ==== tb_spi_sine.sv ====
module tb_spi_sine
    import spi_sine_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int NUM_TESTS     = 7;
    localparam int BYTE_CLKS     = 16 * CLKS_PER_HALF_BIT;          // Clocks per SPI byte
    localparam int RESULT_LIMIT  = 8 * BYTE_CLKS;                   // Per-request wait bound
    localparam int WATCHDOG_TIME = NUM_TESTS * 40 * BYTE_CLKS * CLK_PERIOD;

    logic                       clk;
    logic                       reset;
    logic                       start;
    logic                       spi_miso;
    logic                       spi_clk;
    logic                       spi_mosi;
    logic                       spi_cs_n;
    logic                       busy;
    logic [NUM_UART-1:0]        chan_valid;
    logic signed [SAMPLE_W-1:0] chan_sample;
    logic                       id_error;
    logic [INDEX_W+ID_W-1:0]    slave_word;          // Word the slave returns
    logic [INDEX_W+ID_W-1:0]    slave_rx_word;
    logic [7:0]                 slave_bit_count;

    logic [SAMPLE_W-1:0]        table_mag [2**LUT_ADDR_W];
    logic signed [SAMPLE_W-1:0] last_routed;         // Sample a bad id must leave alone
    logic                       have_routed = 1'b0;

    spi_sine_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .i_start       (start),
        .i_spi_miso    (spi_miso),
        .o_spi_clk     (spi_clk),
        .o_spi_mosi    (spi_mosi),
        .o_spi_cs_n    (spi_cs_n),
        .o_busy        (busy),
        .o_chan_valid  (chan_valid),
        .o_chan_sample (chan_sample),
        .o_id_error    (id_error)
    );

    spi_slave_model slave0 (
        .i_word      (slave_word),
        .i_spi_clk   (spi_clk),
        .i_spi_mosi  (spi_mosi),
        .i_spi_cs_n  (spi_cs_n),
        .o_spi_miso  (spi_miso),
        .o_rx_word   (slave_rx_word),
        .o_bit_count (slave_bit_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before all tests finished");
        fail_run();
    end

    task automatic fail_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic sample_check(input string name, input logic signed [SAMPLE_W-1:0] exp,
                                input logic signed [SAMPLE_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: sample expected %0d actual %0d", name, exp, act);
            fail_run();
        end
    endtask

    task automatic strobe_check(input string name, input logic [NUM_UART-1:0] exp,
                                input logic [NUM_UART-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: channel strobe expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    task automatic flag_check(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: flag expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    task automatic byte_check(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("ERROR %s: byte expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic count_check(input string name, input int exp, input int act);
        if (act !== exp) begin
            $display("ERROR %s: count expected %0d actual %0d", name, exp, act);
            fail_run();
        end
    endtask

    // Quadrant in index bits 11:10, table address in bits 9:5
    function automatic logic signed [SAMPLE_W-1:0] expected_sample(
        input logic [INDEX_W-1:0] index);
        int quadrant;
        int addr;
        int mag;
        quadrant = index[11:10];
        addr     = index[9:5];
        if (quadrant == 1 || quadrant == 3) begin
            addr = (2**LUT_ADDR_W - 1) - addr;      // Falling side of each half wave
        end
        mag = table_mag[addr];
        if (quadrant >= 2) begin
            mag = -mag;                              // Negative half wave
        end
        return SAMPLE_W'(mag);
    endfunction

    task automatic pulse_start(input logic [INDEX_W+ID_W-1:0] word);
        @(negedge clk);
        slave_word = word;
        start      = 1'b1;
        @(negedge clk);
        start      = 1'b0;
    endtask

    task automatic wait_result(input string name);
        int cycles;
        cycles = 0;
        while (chan_valid === '0 && id_error === 1'b0 && cycles < RESULT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= RESULT_LIMIT) begin
            $display("Test %s saw no channel strobe or id error in %0d cycles", name, cycles);
            fail_run();
        end
    endtask

    task automatic check_result(input string name, input logic [INDEX_W+ID_W-1:0] word);
        logic [ID_W-1:0]            id;
        logic [NUM_UART-1:0]        exp_chan;
        logic signed [SAMPLE_W-1:0] exp_sample;
        id       = word[ID_W-1:0];
        exp_chan = '0;
        if (id < NUM_UART) begin
            exp_chan[id] = 1'b1;
            exp_sample   = expected_sample(word[INDEX_W+ID_W-1:ID_W]);
            strobe_check(name, exp_chan, chan_valid);
            flag_check(name, 1'b0, id_error);
            sample_check(name, exp_sample, chan_sample);
            last_routed  = exp_sample;
            have_routed  = 1'b1;
        end else begin
            strobe_check(name, '0, chan_valid);
            flag_check(name, 1'b1, id_error);
            if (have_routed) begin
                sample_check(name, last_routed, chan_sample);   // Held through bad id
            end
        end
        @(negedge clk);
        strobe_check(name, '0, chan_valid);          // Strobes last one cycle
        flag_check(name, 1'b0, id_error);
    endtask

    task automatic run_word(input string name, input logic [INDEX_W+ID_W-1:0] word);
        pulse_start(word);
        wait_result(name);
        check_result(name, word);
    endtask

    task automatic reset_idle_test();
        flag_check("reset_idle cs_n", 1'b1, spi_cs_n);
        flag_check("reset_idle spi_clk", 1'b0, spi_clk);
        flag_check("reset_idle busy", 1'b0, busy);
        flag_check("reset_idle id_error", 1'b0, id_error);
        strobe_check("reset_idle", '0, chan_valid);
    endtask

    task automatic valid_id_test();
        run_word("valid_id", 16'h5A32);              // Index 0x5A3 to channel 2
    endtask

    task automatic quadrant_test();
        logic [INDEX_W-1:0] index;
        for (int q = 0; q < 4; q++) begin
            for (int k = 0; k < 2; k++) begin
                index = {2'(q), (k == 0) ? 5'd0 : 5'd31, 5'b10110};   // Table ends
                run_word("quadrant", {index, 4'(q)});
            end
        end
    endtask

    task automatic bad_id_test();
        int ids[3] = '{NUM_UART, 9, 15};
        foreach (ids[i]) begin
            run_word("bad_id", {12'h2C7, 4'(ids[i])});
        end
    endtask

    task automatic command_capture_test();
        run_word("command_capture", 16'hC7A1);
        byte_check("command_capture first", REQ_COMMAND, slave_rx_word[15:8]);
        byte_check("command_capture second", REQ_COMMAND, slave_rx_word[7:0]);
        count_check("command_capture bits in one cs window", 16, slave_bit_count);
        flag_check("command_capture cs_n after", 1'b1, spi_cs_n);
    endtask

    task automatic busy_start_test();
        int extra;
        pulse_start(16'h9D43);
        repeat (4) @(negedge clk);
        flag_check("busy_start busy", 1'b1, busy);
        start = 1'b1;                                // Should be dropped
        @(negedge clk);
        start = 1'b0;
        wait_result("busy_start");
        check_result("busy_start", 16'h9D43);
        extra = 0;
        repeat (RESULT_LIMIT) begin
            @(negedge clk);
            if (chan_valid !== '0 || id_error !== 1'b0) begin
                extra++;
            end
        end
        count_check("busy_start extra results", 0, extra);
        flag_check("busy_start busy after", 1'b0, busy);
    endtask

    task automatic random_word_test();
        logic [INDEX_W+ID_W-1:0] word;
        repeat (20) begin
            word = 16'($urandom());
            run_word("random_word", word);
        end
    endtask

    initial begin
        void'($urandom(32'h14b4cfda));
        $readmemh(LUT_FILE, table_mag);
        reset      = 1'b1;
        start      = 1'b0;
        slave_word = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_idle_test();
        valid_id_test();
        quadrant_test();
        bad_id_test();
        command_capture_test();
        busy_start_test();
        random_word_test();
        $display("No errors");
        $finish;
    end

endmodule

// ==== sine_quarter.hex ====
// One column: 12-bit magnitude per table address 0 to 31, in hex
// Entry n is round(2047 * sin((2n + 1) * pi / 128))
032
097
0FB
15E
1C1
222
282
2E1
33E
398
3F1
447
49B
4EB
539
583
5CB
60E
64E
68A
6C1
6F5
724
74F
776
798
7B5
7CD
7E1
7F0
7F9
7FE

// ==== spi_sine.f ====
spi_sine_pkg.sv
spi_master_cs.sv
spi_word_request.sv
sine_quarter_lut.sv
sample_dispatch.sv
spi_sine_top.sv
spi_slave_model.sv
tb_spi_sine.sv
